// ==== source/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// general registers, register 0 included
`define CPU_REG_NUM 32

// data path and address width
`define CPU_XLEN 32

`endif

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	// decoded operation class, one per pipeline slot
	typedef enum logic [3:0] {
		OP_NOP,
		OP_ALU,
		OP_LW,
		OP_SW,
		OP_MULT,
		OP_MFHI,
		OP_MFLO,
		OP_BEQ,
		OP_BNE
	} op_t;

	// alu function
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		// upper half load, operand b shifted up
		ALU_LUI
	} alu_op_t;

	// wishbone master state
	typedef enum logic {
		BUS_IDLE,
		BUS_WAIT
	} bus_state_t;

endpackage

// ==== source/regfile.sv ====
`include "cpu_settings.svh"
`timescale 1ns/1ns

module regfile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  raddr_a,
	input  logic [4:0]  raddr_b,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	// register 0 is not stored
	logic [`CPU_XLEN-1:0] regs [1:`CPU_REG_NUM-1];

	// same-cycle write shows up on the read port
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		if (we && (addr == waddr))
			return wdata;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < `CPU_REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rdata_a = read_port(raddr_a);
		rdata_b = read_port(raddr_b);
	end

endmodule

// ==== source/hilo.sv ====
`timescale 1ns/1ns

module hilo (
	input  logic        clk,
	input  logic        rst,
	input  logic        we,
	input  logic [63:0] wdata,
	output logic [63:0] rdata
);

	// hi in the upper word, lo in the lower
	logic [63:0] value;

	always_ff @(posedge clk) begin
		if (rst) begin
			value <= '0;
		end else if (we) begin
			value <= wdata;
		end
	end

	// write-through
	assign rdata = we ? wdata : value;

endmodule

// ==== source/instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode (
	input  logic [31:0]      instr,
	input  logic [31:0]      pc,
	output logic [4:0]       raddr_a,
	output logic [4:0]       raddr_b,
	input  logic [31:0]      rdata_a,
	input  logic [31:0]      rdata_b,
	output cpu_pkg::op_t     op,
	output cpu_pkg::alu_op_t alu_op,
	output logic [31:0]      src_a,
	output logic [31:0]      src_b,
	output logic             imm_sel,
	output logic [31:0]      imm,
	output logic [4:0]       rd,
	output logic [4:0]       rs,
	output logic [4:0]       rt,
	output logic [31:0]      branch_target
);
	import cpu_pkg::*;

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [31:0] simm;
	logic [31:0] zimm;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign simm = {{16{instr[15]}}, instr[15:0]};
	assign zimm = {16'h0000, instr[15:0]};

	assign raddr_a = rs;
	assign raddr_b = rt;
	assign src_a = rdata_a;
	assign src_b = rdata_b;

	// offset counts from the delay slot
	assign branch_target = pc + 32'd4 + {simm[29:0], 2'b00};

	always_comb begin
		op = OP_NOP;
		alu_op = ALU_ADD;
		imm_sel = 1'b0;
		imm = simm;
		rd = 5'd0;
		case (opcode)
		6'h00: begin
			rd = instr[15:11];
			case (funct)
			6'h21: op = OP_ALU;
			6'h23: begin
				op = OP_ALU;
				alu_op = ALU_SUB;
			end
			6'h24: begin
				op = OP_ALU;
				alu_op = ALU_AND;
			end
			6'h25: begin
				op = OP_ALU;
				alu_op = ALU_OR;
			end
			6'h26: begin
				op = OP_ALU;
				alu_op = ALU_XOR;
			end
			6'h2a: begin
				op = OP_ALU;
				alu_op = ALU_SLT;
			end
			6'h10: op = OP_MFHI;
			6'h12: op = OP_MFLO;
			6'h18: op = OP_MULT;
			default: op = OP_NOP;
			endcase
			// mult and unknown functs write no register
			if (op == OP_MULT || op == OP_NOP)
				rd = 5'd0;
		end
		6'h09, 6'h0d, 6'h0f, 6'h23: begin
			op = (opcode == 6'h23) ? OP_LW : OP_ALU;
			imm_sel = 1'b1;
			rd = rt;
			if (opcode == 6'h0d) begin
				alu_op = ALU_OR;
				imm = zimm;
			end else if (opcode == 6'h0f) begin
				alu_op = ALU_LUI;
				imm = zimm;
			end
		end
		6'h2b: begin
			op = OP_SW;
			imm_sel = 1'b1;
		end
		6'h04: op = OP_BEQ;
		6'h05: op = OP_BNE;
		default: op = OP_NOP;
		endcase
	end

endmodule

// ==== source/instr_exec.sv ====
`timescale 1ns/1ns

module instr_exec (
	input  cpu_pkg::op_t     op,
	input  cpu_pkg::alu_op_t alu_op,
	input  logic [31:0]      src_a,
	input  logic [31:0]      src_b,
	input  logic [31:0]      imm,
	input  logic             imm_sel,
	input  logic [4:0]       rs,
	input  logic [4:0]       rt,
	input  logic [4:0]       fwd_mem_rd,
	input  logic [31:0]      fwd_mem_data,
	input  logic [4:0]       fwd_wb_rd,
	input  logic [31:0]      fwd_wb_data,
	input  logic             hilo_mem_we,
	input  logic [63:0]      hilo_mem,
	input  logic [63:0]      hilo,
	output logic [31:0]      result,
	output logic [31:0]      store_data,
	output logic [63:0]      product,
	output logic             branch_taken
);
	import cpu_pkg::*;

	logic [31:0] opa;
	logic [31:0] opb;
	logic [31:0] alu_b;
	logic [31:0] alu_out;
	logic [63:0] hilo_cur;

	// newest producer first, register 0 never forwarded
	function automatic logic [31:0] forward(input logic [4:0] r, input logic [31:0] v);
		if (r == 5'd0)
			return v;
		if (r == fwd_mem_rd)
			return fwd_mem_data;
		if (r == fwd_wb_rd)
			return fwd_wb_data;
		return v;
	endfunction

	always_comb begin
		opa = forward(rs, src_a);
		opb = forward(rt, src_b);
	end

	assign alu_b = imm_sel ? imm : opb;
	assign store_data = opb;

	always_comb begin
		case (alu_op)
		ALU_SUB: alu_out = opa - alu_b;
		ALU_AND: alu_out = opa & alu_b;
		ALU_OR:  alu_out = opa | alu_b;
		ALU_XOR: alu_out = opa ^ alu_b;
		ALU_SLT: alu_out = {31'd0, $signed(opa) < $signed(alu_b)};
		ALU_LUI: alu_out = {alu_b[15:0], 16'h0000};
		// add, also the lw/sw address
		default: alu_out = opa + alu_b;
		endcase
	end

	assign product = $signed(opa) * $signed(opb);

	// mult still in MEM has not reached HI/LO yet
	assign hilo_cur = hilo_mem_we ? hilo_mem : hilo;

	always_comb begin
		case (op)
		OP_MFHI: result = hilo_cur[63:32];
		OP_MFLO: result = hilo_cur[31:0];
		default: result = alu_out;
		endcase
	end

	assign branch_taken = ((op == OP_BEQ) && (opa == opb)) ||
		((op == OP_BNE) && (opa != opb));

endmodule

// ==== source/mem_access.sv ====
`timescale 1ns/1ns

module mem_access (
	input  logic         clk,
	input  logic         rst,
	input  cpu_pkg::op_t op,
	input  logic [31:0]  addr,
	input  logic [31:0]  store_data,
	output logic         wb_cyc,
	output logic         wb_stb,
	output logic         wb_we,
	output logic [31:0]  wb_adr,
	output logic [31:0]  wb_dat_o,
	output logic [3:0]   wb_sel,
	input  logic [31:0]  wb_dat_i,
	input  logic         wb_ack,
	output logic [31:0]  load_data,
	output logic         stall_req
);
	import cpu_pkg::*;

	bus_state_t state;
	logic       done;
	logic       is_mem;
	logic       start;

	assign is_mem = (op == OP_LW) || (op == OP_SW);
	// done marks the access of the instruction still sitting in MEM
	assign start = (state == BUS_IDLE) && is_mem && !done;
	assign stall_req = start || (state == BUS_WAIT);
	assign wb_sel = 4'hf;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BUS_IDLE;
			done <= 1'b0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			case (state)
			BUS_IDLE: begin
				done <= 1'b0;
				if (start) begin
					state <= BUS_WAIT;
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we <= (op == OP_SW);
				end
			end
			BUS_WAIT: begin
				if (wb_ack) begin
					state <= BUS_IDLE;
					done <= 1'b1;
					wb_cyc <= 1'b0;
					wb_stb <= 1'b0;
				end
			end
			default: state <= BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			wb_adr <= addr;
			wb_dat_o <= store_data;
		end
		if ((state == BUS_WAIT) && wb_ack)
			load_data <= wb_dat_i;
	end

endmodule

// ==== source/pipeline_ctrl.sv ====
`timescale 1ns/1ns

module pipeline_ctrl (
	input  logic [4:0]   id_rs,
	input  logic [4:0]   id_rt,
	input  cpu_pkg::op_t ex_op,
	input  logic [4:0]   ex_rd,
	input  logic         branch_taken,
	input  logic         mem_stall,
	output logic         stall_if,
	output logic         stall_id,
	output logic         stall_ex,
	output logic         stall_mem,
	output logic         flush_if,
	output logic         flush_ex
);
	import cpu_pkg::*;

	logic load_use;

	// load data only exists once the lw is in WB
	assign load_use = (ex_op == OP_LW) && (ex_rd != 5'd0) &&
		((ex_rd == id_rs) || (ex_rd == id_rt));

	// bus stall freezes the whole pipe
	assign stall_mem = mem_stall;
	assign stall_ex = mem_stall;
	assign stall_id = mem_stall || load_use;
	assign stall_if = mem_stall || load_use;

	assign flush_ex = load_use && !mem_stall;
	// wrong-path fetch behind the delay slot
	assign flush_if = branch_taken && !mem_stall;

endmodule

// ==== source/cpu_core.sv ====
`include "cpu_settings.svh"
`timescale 1ns/1ns

module cpu_core (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output logic [31:0] wb_adr,
	output logic [31:0] wb_dat_o,
	output logic [3:0]  wb_sel,
	input  logic [31:0] wb_dat_i,
	input  logic        wb_ack
);
	import cpu_pkg::*;

	logic stall_if, stall_id, stall_ex, stall_mem;
	logic flush_if, flush_ex, mem_stall;

	logic [31:0] pc, id_instr, id_pc;

	// decode outputs
	logic [4:0]  rf_raddr_a, rf_raddr_b;
	logic [31:0] rf_rdata_a, rf_rdata_b;
	op_t         id_op;
	alu_op_t     id_alu_op;
	logic [31:0] id_src_a, id_src_b, id_imm, id_branch_target;
	logic        id_imm_sel;
	logic [4:0]  id_rd, id_rs, id_rt;

	// ID/EX and EX results
	op_t         ex_op;
	alu_op_t     ex_alu_op;
	logic [31:0] ex_src_a, ex_src_b, ex_imm, ex_branch_target;
	logic        ex_imm_sel;
	logic [4:0]  ex_rd, ex_rs, ex_rt;
	logic [31:0] ex_result, ex_store_data;
	logic [63:0] ex_product, hilo_rdata;
	logic        ex_branch_taken;

	// EX/MEM
	op_t         mem_op;
	logic [4:0]  mem_rd;
	logic [31:0] mem_result, mem_store_data, mem_load_data;
	logic [63:0] mem_product;

	// MEM/WB, the register file write port
	logic        rf_we;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;

	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `CPU_RESET_PC;
		end else if (flush_if) begin
			pc <= ex_branch_target;
		end else if (!stall_if) begin
			pc <= pc + 32'd4;
		end
	end

	// IF/ID
	always_ff @(posedge clk) begin
		if (rst || flush_if) begin
			id_instr <= '0;
			id_pc <= '0;
		end else if (!stall_id) begin
			id_instr <= imem_data;
			id_pc <= pc;
		end
	end

	pipeline_ctrl pipeline_ctrl_inst (
		.id_rs        ( id_rs           ),
		.id_rt        ( id_rt           ),
		.ex_op        ( ex_op           ),
		.ex_rd        ( ex_rd           ),
		.branch_taken ( ex_branch_taken ),
		.mem_stall,
		.stall_if,
		.stall_id,
		.stall_ex,
		.stall_mem,
		.flush_if,
		.flush_ex
	);

	regfile regfile_inst (
		.clk,
		.rst,
		.raddr_a ( rf_raddr_a ),
		.raddr_b ( rf_raddr_b ),
		.rdata_a ( rf_rdata_a ),
		.rdata_b ( rf_rdata_b ),
		.we      ( rf_we      ),
		.waddr   ( rf_waddr   ),
		.wdata   ( rf_wdata   )
	);

	hilo hilo_inst (
		.clk,
		.rst,
		.we    ( (mem_op == OP_MULT) && !stall_mem ),
		.wdata ( mem_product                       ),
		.rdata ( hilo_rdata                        )
	);

	instr_decode decode_inst (
		.instr   ( id_instr   ),
		.pc      ( id_pc      ),
		.raddr_a ( rf_raddr_a ),
		.raddr_b ( rf_raddr_b ),
		.rdata_a ( rf_rdata_a ),
		.rdata_b ( rf_rdata_b ),
		.op      ( id_op      ),
		.alu_op  ( id_alu_op  ),
		.src_a   ( id_src_a   ),
		.src_b   ( id_src_b   ),
		.imm_sel ( id_imm_sel ),
		.imm     ( id_imm     ),
		.rd      ( id_rd      ),
		.rs      ( id_rs      ),
		.rt      ( id_rt      ),
		.branch_target ( id_branch_target )
	);

	// ID/EX
	always_ff @(posedge clk) begin
		if (rst || flush_ex) begin
			ex_op <= OP_NOP;
			ex_alu_op <= ALU_ADD;
			ex_rd <= 5'd0;
			ex_rs <= 5'd0;
			ex_rt <= 5'd0;
		end else if (stall_ex) begin
			// WB drains during a bus stall, so catch its value here
			if (rf_we && (rf_waddr != 5'd0) && (rf_waddr == ex_rs))
				ex_src_a <= rf_wdata;
			if (rf_we && (rf_waddr != 5'd0) && (rf_waddr == ex_rt))
				ex_src_b <= rf_wdata;
		end else begin
			ex_op <= id_op;
			ex_alu_op <= id_alu_op;
			ex_rd <= id_rd;
			ex_rs <= id_rs;
			ex_rt <= id_rt;
			ex_src_a <= id_src_a;
			ex_src_b <= id_src_b;
			ex_imm <= id_imm;
			ex_imm_sel <= id_imm_sel;
			ex_branch_target <= id_branch_target;
		end
	end

	instr_exec exec_inst (
		.op           ( ex_op                                ),
		.alu_op       ( ex_alu_op                            ),
		.src_a        ( ex_src_a                             ),
		.src_b        ( ex_src_b                             ),
		.imm          ( ex_imm                               ),
		.imm_sel      ( ex_imm_sel                           ),
		.rs           ( ex_rs                                ),
		.rt           ( ex_rt                                ),
		.fwd_mem_rd   ( (mem_op == OP_LW) ? 5'd0 : mem_rd    ),
		.fwd_mem_data ( mem_result                           ),
		.fwd_wb_rd    ( rf_we ? rf_waddr : 5'd0              ),
		.fwd_wb_data  ( rf_wdata                             ),
		.hilo_mem_we  ( mem_op == OP_MULT                    ),
		.hilo_mem     ( mem_product                          ),
		.hilo         ( hilo_rdata                           ),
		.result       ( ex_result                            ),
		.store_data   ( ex_store_data                        ),
		.product      ( ex_product                           ),
		.branch_taken ( ex_branch_taken                      )
	);

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_op <= OP_NOP;
			mem_rd <= 5'd0;
		end else if (!stall_mem) begin
			mem_op <= ex_op;
			mem_rd <= ex_rd;
			mem_result <= ex_result;
			mem_store_data <= ex_store_data;
			mem_product <= ex_product;
		end
	end

	mem_access mem_access_inst (
		.clk,
		.rst,
		.op         ( mem_op         ),
		.addr       ( mem_result     ),
		.store_data ( mem_store_data ),
		.wb_cyc,
		.wb_stb,
		.wb_we,
		.wb_adr,
		.wb_dat_o,
		.wb_sel,
		.wb_dat_i,
		.wb_ack,
		.load_data  ( mem_load_data  ),
		.stall_req  ( mem_stall      )
	);

	// MEM/WB, bubbles while the bus holds MEM
	always_ff @(posedge clk) begin
		if (rst || stall_mem) begin
			rf_we <= 1'b0;
			rf_waddr <= 5'd0;
		end else begin
			rf_we <= mem_op inside {OP_ALU, OP_LW, OP_MFHI, OP_MFLO};
			rf_waddr <= mem_rd;
			rf_wdata <= (mem_op == OP_LW) ? mem_load_data : mem_result;
		end
	end

endmodule

// ==== bench/cpu_chk.sv ====
`timescale 1ns/1ns

module cpu_chk (
	input logic                clk,
	input logic                rst,
	input logic                wb_cyc,
	input logic                wb_stb,
	input logic                wb_we,
	input logic [31:0]         wb_adr,
	input logic [31:0]         wb_dat_o,
	input logic                wb_ack,
	input logic [31:0]         pc,
	input cpu_pkg::op_t        mem_op,
	input logic                rf_we,
	input cpu_pkg::bus_state_t bus_state
);
	import cpu_pkg::*;

	// strobe only inside an open cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
		else $error("wb_stb high without wb_cyc");

	// request held steady until ack
	req_stable: assert property (@(posedge clk) disable iff (rst)
		(wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_we)))
		else $error("wishbone request changed before ack");

	idle_after_reset: assert property (@(posedge clk) rst |=> (!wb_cyc && !wb_stb))
		else $error("bus cycle open right after reset");

	// bus wait freezes fetch and MEM and bubbles WB
	wait_stalls: assert property (@(posedge clk) disable iff (rst)
		(bus_state == BUS_WAIT) |=> ($stable(pc) && $stable(mem_op) && !rf_we))
		else $error("pipeline kept moving while the bus waits for ack");

endmodule

bind cpu_core cpu_chk chk_inst (
	.clk,
	.rst,
	.wb_cyc,
	.wb_stb,
	.wb_we,
	.wb_adr,
	.wb_dat_o,
	.wb_ack,
	.pc,
	.mem_op,
	.rf_we,
	.bus_state ( mem_access_inst.state )
);

// ==== bench/tb_cpu.sv ====
`include "cpu_settings.svh"
`timescale 1ns/1ns

module tb_cpu;
	import cpu_pkg::*;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_o;
	logic [3:0]  wb_sel;
	logic [31:0] wb_dat_i;
	logic        wb_ack;

	logic [31:0] imem [0:511];
	logic [31:0] dmem [0:511];
	logic [31:0] model_mem [0:511];
	logic [31:0] exp_adr [$];
	logic [31:0] exp_dat [$];
	logic [31:0] lfsr = 32'hf6324046;
	logic [31:0] end_pc;
	int          prog_len;
	int          exp_count;
	int          exp_loads;
	int          n_stores = 0;
	int          n_loads = 0;
	int          ack_wait = 0;

	cpu_core DUT (
		.clk,
		.rst,
		.imem_addr,
		.imem_data,
		.wb_cyc,
		.wb_stb,
		.wb_we,
		.wb_adr,
		.wb_dat_o,
		.wb_sel,
		.wb_dat_i,
		.wb_ack
	);

	// instruction port answers in the same cycle
	assign imem_data = imem[imem_addr[10:2]];

	always #4 clk = ~clk;

	task automatic end_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_problem(input string msg);
		$display("%0t ns: %s", $time, msg);
		end_with_failure();
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_sel(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_op(input string name, input op_t got, input op_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %s, expected %s", $time, name, got.name(),
				exp.name());
			end_with_failure();
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [31:0] fill_word(input int idx);
		logic [31:0] a;
		a = 32'(idx) << 2;
		return (a * 32'h9e3779b1) ^ {a[15:0], ~a[15:0]};
	endfunction

	function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] opc, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// one instruction that is neither a branch nor a mult
	task automatic emit_simple();
		logic [3:0]  kind;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		kind = 4'(rand_bits(4));
		rs = 5'(rand_bits(4));
		rt = 5'(rand_bits(4));
		rd = 5'(rand_bits(4));
		imm = 16'(rand_bits(16));
		case (kind)
		4'd0, 4'd13: emit(r_type(rs, rt, rd, 6'h21));
		4'd1: emit(r_type(rs, rt, rd, 6'h23));
		4'd2: emit(r_type(rs, rt, rd, 6'h24));
		4'd3: emit(r_type(rs, rt, rd, 6'h25));
		4'd4: emit(r_type(rs, rt, rd, 6'h26));
		4'd5: emit(r_type(rs, rt, rd, 6'h2a));
		4'd6: emit(i_type(6'h09, rs, rt, imm));
		4'd7: emit(i_type(6'h0d, rs, rt, imm));
		4'd8: emit(i_type(6'h0f, 5'd0, rt, imm));
		// data region is 64 words at address 0
		4'd9, 4'd14: emit(i_type(6'h23, 5'd0, rt, {8'h00, imm[5:0], 2'b00}));
		4'd10, 4'd15: emit(i_type(6'h2b, 5'd0, rt, {8'h00, imm[5:0], 2'b00}));
		4'd11: emit(r_type(5'd0, 5'd0, rd, 6'h10));
		default: emit(r_type(5'd0, 5'd0, rd, 6'h12));
		endcase
	endtask

	task automatic build_program();
		logic [31:0] v;
		logic [3:0]  kind;
		logic [4:0]  rs;
		logic [4:0]  rt;
		int          n;
		prog_len = 0;
		for (int r = 1; r < 16; r++) begin
			v = rand_bits(32);
			emit(i_type(6'h0f, 5'd0, 5'(r), v[31:16]));
			emit(i_type(6'h0d, 5'(r), 5'(r), v[15:0]));
		end
		n = 0;
		while (n < 200) begin
			kind = 4'(rand_bits(4));
			if (kind >= 4'd14 && n < 190) begin
				rs = 5'(rand_bits(4));
				rt = rand_bits(1) ? rs : 5'(rand_bits(4));
				// forward only, past the delay slot
				emit(i_type((kind == 4'd14) ? 6'h04 : 6'h05, rs, rt,
					16'(2 + int'(rand_bits(2)))));
				emit_simple();
				n += 2;
			end else if (kind == 4'd12 && n < 197) begin
				emit(r_type(5'(rand_bits(4)), 5'(rand_bits(4)), 5'd0, 6'h18));
				emit(r_type(5'd0, 5'd0, 5'(rand_bits(4)), 6'h10));
				emit(r_type(5'd0, 5'd0, 5'(rand_bits(4)), 6'h12));
				n += 3;
			end else begin
				emit_simple();
				n += 1;
			end
		end
		// register dump, then spin
		for (int r = 1; r < 16; r++)
			emit(i_type(6'h2b, 5'd0, 5'(r), 16'(32'h400 + 4 * r)));
		end_pc = 32'(prog_len) << 2;
		emit(i_type(6'h04, 5'd0, 5'd0, 16'hffff));
		emit(32'h0000_0000);
	endtask

	// architectural model with one delay slot
	task automatic run_model();
		logic [31:0]        regs [0:31];
		logic [31:0]        hi;
		logic [31:0]        lo;
		logic [31:0]        pc;
		logic [31:0]        npc;
		logic [31:0]        nnpc;
		logic [31:0]        ins;
		logic [31:0]        a;
		logic [31:0]        b;
		logic [31:0]        simm;
		logic [31:0]        addr;
		logic [4:0]         rd;
		logic [4:0]         rt;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] prod;
		int                 steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		hi = '0;
		lo = '0;
		pc = `CPU_RESET_PC;
		npc = pc + 32'd4;
		steps = 0;
		exp_loads = 0;
		while (pc != end_pc) begin
			if (steps > 5000)
				report_problem("reference model never reached the final loop");
			ins = imem[pc[10:2]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			rt = ins[20:16];
			rd = ins[15:11];
			simm = {{16{ins[15]}}, ins[15:0]};
			addr = a + simm;
			nnpc = npc + 32'd4;
			case (ins[31:26])
			6'h00: begin
				case (ins[5:0])
				6'h21: regs[rd] = a + b;
				6'h23: regs[rd] = a - b;
				6'h24: regs[rd] = a & b;
				6'h25: regs[rd] = a | b;
				6'h26: regs[rd] = a ^ b;
				6'h2a: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				6'h10: regs[rd] = hi;
				6'h12: regs[rd] = lo;
				6'h18: begin
					sa = $signed(a);
					sb = $signed(b);
					prod = sa * sb;
					hi = prod[63:32];
					lo = prod[31:0];
				end
				default: ;
				endcase
			end
			6'h09: regs[rt] = addr;
			6'h0d: regs[rt] = a | {16'h0000, ins[15:0]};
			6'h0f: regs[rt] = {ins[15:0], 16'h0000};
			6'h23: begin
				regs[rt] = model_mem[addr[10:2]];
				exp_loads++;
			end
			6'h2b: begin
				model_mem[addr[10:2]] = b;
				exp_adr.push_back(addr);
				exp_dat.push_back(b);
			end
			6'h04: if (a == b) nnpc = pc + 32'd4 + {simm[29:0], 2'b00};
			6'h05: if (a != b) nnpc = pc + 32'd4 + {simm[29:0], 2'b00};
			default: ;
			endcase
			regs[0] = '0;
			pc = npc;
			npc = nnpc;
			steps++;
		end
	endtask

	task automatic complete_access();
		int idx;
		idx = int'(wb_adr[10:2]);
		check_sel("wb_sel", wb_sel, 4'hf);
		if (wb_we) begin
			if (exp_adr.size() == 0)
				report_problem("a store appeared after all expected stores were seen");
			check_op("mem_op", DUT.mem_op, OP_SW);
			check_word("wb_adr", wb_adr, exp_adr.pop_front());
			check_word("wb_dat_o", wb_dat_o, exp_dat.pop_front());
			dmem[idx] = wb_dat_o;
			n_stores++;
		end else begin
			wb_dat_i = dmem[idx];
			n_loads++;
		end
		wb_ack = 1'b1;
	endtask

	// wishbone slave, ack 1 to 4 cycles after stb is seen
	always begin
		@(posedge clk);
		#1;
		if (wb_ack) begin
			wb_ack = 1'b0;
			wb_dat_i = '0;
		end else if (!rst && wb_cyc && wb_stb) begin
			if (ack_wait == 0) begin
				ack_wait = 1 + int'(rand_bits(2));
			end else begin
				ack_wait = ack_wait - 1;
				if (ack_wait == 0)
					complete_access();
			end
		end
	end

	initial begin
		int cycles;
		rst = 1'b1;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		for (int i = 0; i < 512; i++) begin
			imem[i] = '0;
			dmem[i] = fill_word(i);
			model_mem[i] = fill_word(i);
		end
		build_program();
		run_model();
		exp_count = exp_adr.size();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		check_word("imem_addr", imem_addr, `CPU_RESET_PC);
		check_bit("wb_cyc", wb_cyc, 1'b0);
		check_bit("wb_stb", wb_stb, 1'b0);
		for (cycles = 0; cycles < 20000 && n_stores < exp_count; cycles++)
			@(negedge clk);
		if (n_stores < exp_count)
			report_problem("timed out waiting for the expected stores");
		for (cycles = 0; cycles < 2000 && imem_addr != end_pc; cycles++)
			@(negedge clk);
		if (imem_addr != end_pc)
			report_problem("core never fetched the final loop");
		// late stores trip the slave check and late loads the count
		for (cycles = 0; cycles < 100; cycles++)
			@(negedge clk);
		if (n_loads != exp_loads) begin
			$display("ERROR at %0t ns: load count is %0d, expected %0d", $time, n_loads,
				exp_loads);
			end_with_failure();
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

// ==== tb.f ====
+incdir+source
source/cpu_pkg.sv
source/regfile.sv
source/hilo.sv
source/instr_decode.sv
source/instr_exec.sv
source/mem_access.sv
source/pipeline_ctrl.sv
source/cpu_core.sv
bench/cpu_chk.sv
bench/tb_cpu.sv

// ==== run.sh ====
#!/bin/bash
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f tb.f -o tb_cpu_sim \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/tb_cpu_sim > sim.log 2>&1 || echo "simulator returned a nonzero status"
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "%Error" sim.log && { echo "simulation reported an error"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
